// File: hdl/wb_pipe_pkg.sv
// ============================================================
// Pipeline types shared by the write-back stage and its testbench
// ============================================================
package wb_pipe_pkg;

    // ============================================================
    // Memory access size
    // ============================================================

    // Encoding follows funct3[1:0] of RV32I loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } data_size_e;

    // ============================================================
    // Execute to write-back bundle
    // ============================================================

    // Decoded flags travel with the results
    // Address and branch condition both come in result1
    typedef struct packed {
        // ALU result, memory address, or condition in bit 0
        logic [31:0] result1;
        // Store data or branch target
        logic [31:0] result2;
        // Destination register
        logic [4:0]  rd;
        logic        rd_write;
        // Unconditional branch
        logic        branch;
        // Branch only if result1[0] is set
        logic        branch_cond;
        logic        ld;
        logic        st;
        // Zero extend load data instead of sign extend
        logic        data_uns;
        // Stage halts on this one
        logic        illegal;
        data_size_e  data_size;
    } pipe_ex_wb_t;

endpackage

// File: hdl/data_bus_pkg.sv
// ============================================================
// Data bus request type between load/store unit and memory
// ============================================================
package data_bus_pkg;

    // ============================================================
    // Request bundle
    // ============================================================

    // Held stable from request until data_gnt
    // Read data and grant return as separate signals
    typedef struct packed {
        // Always word aligned
        logic [31:0] addr;
        // Data already steered into byte lanes
        logic [31:0] wr_data;
        // One bit per byte lane
        logic [3:0]  wr_mask;
        // Read request
        logic        rd_req;
        // Write request
        logic        wr_req;
    } data_req_t;

endpackage

// File: hdl/load_store_unit.sv
// ============================================================
// Load/store engine on a word-wide request/grant data bus
// Splits word-crossing accesses into two word requests
// ============================================================
`timescale 1ns/1ns

module load_store_unit
    import wb_pipe_pkg::*;
    import data_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    // Accept pulse from the stage
    input  logic        start,
    input  pipe_ex_wb_t bundle,
    output logic        done,
    // Load result toward the register file
    output logic        load_en,
    output logic [4:0]  load_rd,
    output logic [31:0] load_data,
    // Data bus
    output data_req_t   data_req,
    input  logic [31:0] data_rd_data,
    input  logic        data_gnt
);

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        SECOND
    } lsu_state_e;

    lsu_state_e  state;

    // Latched access
    logic [31:0] addr_q;
    logic [31:0] st_data_q;
    data_size_e  size_q;
    logic        uns_q;
    logic        ld_q;
    // First word of a split load
    logic [31:0] lo_word_q;

    logic [1:0]  offset;
    logic [2:0]  size_bytes;
    logic [3:0]  size_mask;
    logic        split;
    logic        final_gnt;
    logic [31:0] word_addr;
    logic [63:0] st_wide;
    logic [7:0]  mask_wide;
    logic [63:0] ld_pair;
    logic [63:0] ld_shift;
    logic [31:0] ld_ext;

    // ============================================================
    // Access geometry
    // ============================================================

    assign offset    = addr_q[1:0];
    assign word_addr = {addr_q[31:2], 2'b00};

    always_comb begin
        case (size_q)
            SIZE_BYTE: begin
                size_bytes = 3'd1;
                size_mask  = 4'b0001;
            end
            SIZE_HALF: begin
                size_bytes = 3'd2;
                size_mask  = 4'b0011;
            end
            default: begin
                size_bytes = 3'd4;
                size_mask  = 4'b1111;
            end
        endcase
    end

    // Bytes spill into the next word
    assign split = ({1'b0, offset} + size_bytes) > 3'd4;

    assign final_gnt = data_gnt && (((state == FIRST) && !split) || (state == SECOND));

    // Store lanes over two words, upper half used by the second access
    assign st_wide   = {32'b0, st_data_q} << {offset, 3'b000};
    assign mask_wide = {4'b0, size_mask} << offset;

    // ============================================================
    // Bus request
    // ============================================================

    always_comb begin
        data_req.addr    = (state == SECOND) ? word_addr + 32'd4 : word_addr;
        data_req.wr_data = (state == SECOND) ? st_wide[63:32] : st_wide[31:0];
        data_req.wr_mask = (state == SECOND) ? mask_wide[7:4] : mask_wide[3:0];
        data_req.rd_req  = (state != IDLE) && ld_q;
        data_req.wr_req  = (state != IDLE) && !ld_q;
    end

    // ============================================================
    // Load assembly
    // ============================================================

    // Pair the two reads, then drop the leading bytes
    assign ld_pair  = (state == SECOND) ? {data_rd_data, lo_word_q} : {32'b0, data_rd_data};
    assign ld_shift = ld_pair >> {offset, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: ld_ext = uns_q ? {24'b0, ld_shift[7:0]}
                                      : {{24{ld_shift[7]}}, ld_shift[7:0]};
            SIZE_HALF: ld_ext = uns_q ? {16'b0, ld_shift[15:0]}
                                      : {{16{ld_shift[15]}}, ld_shift[15:0]};
            default:   ld_ext = ld_shift[31:0];
        endcase
    end

    // ============================================================
    // Sequencer
    // ============================================================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state   <= IDLE;
            done    <= 1'b0;
            load_en <= 1'b0;
        end else begin
            done    <= final_gnt;
            load_en <= final_gnt && ld_q;
            case (state)
                IDLE:    if (start) state <= FIRST;
                FIRST:   if (data_gnt) state <= split ? SECOND : IDLE;
                SECOND:  if (data_gnt) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q    <= bundle.result1;
            st_data_q <= bundle.result2;
            size_q    <= bundle.data_size;
            uns_q     <= bundle.data_uns;
            ld_q      <= bundle.ld;
            load_rd   <= bundle.rd;
        end
        if ((state == FIRST) && data_gnt) begin
            lo_word_q <= data_rd_data;
        end
        if (final_gnt) begin
            load_data <= ld_ext;
        end
    end

endmodule

// File: hdl/wb_stage.sv
// ============================================================
// Write-back stage sequencer with register write and branch
// Loads and stores go through the load/store unit
// ============================================================
`timescale 1ns/1ns

module wb_stage
    import wb_pipe_pkg::*;
    import data_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    // Pipeline input
    input  pipe_ex_wb_t execute,
    input  logic        pipe_in_vld,
    output logic        pipe_in_rdy,
    // Register write port
    output logic [31:0] regwr_data,
    output logic [4:0]  regwr_sel,
    output logic        regwr_en,
    // Branch
    output logic        branch,
    output logic [31:0] branch_target,
    // Data bus
    output data_req_t   data_req,
    input  logic [31:0] data_rd_data,
    input  logic        data_gnt
);

    typedef enum logic [1:0] {
        WRITE,
        LSU,
        CATCH
    } wb_state_e;

    wb_state_e   state;
    wb_state_e   next_state;

    logic        accept;
    logic        direct;
    logic        lsu_start;
    logic        lsu_done;
    logic        load_en;
    logic [4:0]  load_rd;
    logic [31:0] load_data;

    // Direct write registers
    logic        wr_en_q;
    logic [4:0]  wr_sel_q;
    logic [31:0] wr_data_q;

    // ============================================================
    // Sequencer
    // ============================================================

    // Ready again in the cycle the unit reports done
    assign pipe_in_rdy = (state == WRITE) || lsu_done;
    assign accept      = pipe_in_vld && pipe_in_rdy;

    // Plain result or branch, finished in one cycle
    assign direct    = accept && !execute.illegal && !execute.ld && !execute.st;
    assign lsu_start = accept && !execute.illegal && (execute.ld || execute.st);

    always_comb begin
        next_state = state;
        if (accept) begin
            if (execute.illegal) begin
                next_state = CATCH;
            end else if (execute.ld || execute.st) begin
                next_state = LSU;
            end else begin
                next_state = WRITE;
            end
        end else if (lsu_done) begin
            next_state = WRITE;
        end
    end

    // CATCH only leaves through reset
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= WRITE;
        end else begin
            state <= next_state;
        end
    end

    // ============================================================
    // Load/store unit
    // ============================================================

    load_store_unit u_lsu (
        .clk          (clk),
        .rstz         (rstz),
        .start        (lsu_start),
        .bundle       (execute),
        .done         (lsu_done),
        .load_en      (load_en),
        .load_rd      (load_rd),
        .load_data    (load_data),
        .data_req     (data_req),
        .data_rd_data (data_rd_data),
        .data_gnt     (data_gnt)
    );

    // ============================================================
    // Register write and branch
    // ============================================================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wr_en_q <= 1'b0;
            branch  <= 1'b0;
        end else begin
            wr_en_q <= direct && execute.rd_write;
            // Pulse for one cycle only
            branch  <= direct && (execute.branch ||
                                  (execute.branch_cond && execute.result1[0]));
        end
    end

    always_ff @(posedge clk) begin
        if (direct) begin
            wr_sel_q      <= execute.rd;
            wr_data_q     <= execute.result1;
            branch_target <= execute.result2;
        end
    end

    // Load result is already a flop inside the unit
    // Never overlaps a direct write since nothing is accepted during the access
    assign regwr_en   = wr_en_q || load_en;
    assign regwr_sel  = load_en ? load_rd : wr_sel_q;
    assign regwr_data = load_en ? load_data : wr_data_q;

endmodule

// File: hdl/reg_file.sv
// ============================================================
// Architectural register file with one write and a debug read
// ============================================================
`timescale 1ns/1ns

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rstz,
    input  logic        wr_en,
    input  logic [4:0]  wr_sel,
    input  logic [31:0] wr_data,
    input  logic [4:0]  dbg_sel,
    output logic [31:0] dbg_data
);

    localparam int SEL_W = $clog2(REG_COUNT);

    logic [31:0]      regs [REG_COUNT];
    logic [SEL_W-1:0] wr_idx;
    logic [SEL_W-1:0] dbg_idx;
    logic             wr_ok;
    logic             dbg_ok;

    assign wr_idx  = wr_sel[SEL_W-1:0];
    assign dbg_idx = dbg_sel[SEL_W-1:0];

    // x0 and registers beyond REG_COUNT are out of reach
    assign wr_ok  = (wr_sel != 5'd0) && (wr_sel < REG_COUNT);
    assign dbg_ok = (dbg_sel != 5'd0) && (dbg_sel < REG_COUNT);

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_ok) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign dbg_data = dbg_ok ? regs[dbg_idx] : 32'b0;

endmodule

// File: hdl/wb_top.sv
// ============================================================
// Write-back stage with register file, as seen by the testbench
// ============================================================
`timescale 1ns/1ns

module wb_top
    import wb_pipe_pkg::*;
    import data_bus_pkg::*;
#(
    // 16 gives an RV32E register file
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rstz,
    // Pipeline input
    input  pipe_ex_wb_t execute,
    input  logic        pipe_in_vld,
    output logic        pipe_in_rdy,
    // Branch
    output logic        branch,
    output logic [31:0] branch_target,
    // Data bus
    output data_req_t   data_req,
    input  logic [31:0] data_rd_data,
    input  logic        data_gnt,
    // Debug read
    input  logic [4:0]  dbg_sel,
    output logic [31:0] dbg_data
);

    logic [31:0] regwr_data;
    logic [4:0]  regwr_sel;
    logic        regwr_en;

    wb_stage u_wb_stage (
        .clk           (clk),
        .rstz          (rstz),
        .execute       (execute),
        .pipe_in_vld   (pipe_in_vld),
        .pipe_in_rdy   (pipe_in_rdy),
        .regwr_data    (regwr_data),
        .regwr_sel     (regwr_sel),
        .regwr_en      (regwr_en),
        .branch        (branch),
        .branch_target (branch_target),
        .data_req      (data_req),
        .data_rd_data  (data_rd_data),
        .data_gnt      (data_gnt)
    );

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) u_reg_file (
        .clk      (clk),
        .rstz     (rstz),
        .wr_en    (regwr_en),
        .wr_sel   (regwr_sel),
        .wr_data  (regwr_data),
        .dbg_sel  (dbg_sel),
        .dbg_data (dbg_data)
    );

endmodule

// File: tests/tb_wb_top.sv
// ============================================================
// Directed testbench for the write-back stage with register file
// Memory model grants after random delays, checks run per test
// ============================================================
`timescale 1ns/1ns

module tb_wb_top
    import wb_pipe_pkg::*;
    import data_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk;
    logic        rstz;
    pipe_ex_wb_t execute;
    logic        pipe_in_vld;
    logic        pipe_in_rdy;
    logic        branch;
    logic [31:0] branch_target;
    data_req_t   data_req;
    logic [31:0] data_rd_data;
    logic        data_gnt;
    logic [4:0]  dbg_sel;
    logic [31:0] dbg_data;

    // Expected state kept by the tests
    logic [31:0] exp_regs [32];
    logic [31:0] exp_mem [256];
    logic [31:0] stim_seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          cycles;

    // Memory model state
    logic [31:0] mem [256];
    logic [31:0] gnt_seed;
    logic [7:0]  gnt_idx;
    int          wait_left;
    int          gnt_count;
    int          rdy_viol;
    int          misaligned;

    wb_top #(
        .REG_COUNT (32)
    ) dut (
        .clk           (clk),
        .rstz          (rstz),
        .execute       (execute),
        .pipe_in_vld   (pipe_in_vld),
        .pipe_in_rdy   (pipe_in_rdy),
        .branch        (branch),
        .branch_target (branch_target),
        .data_req      (data_req),
        .data_rd_data  (data_rd_data),
        .data_gnt      (data_gnt),
        .dbg_sel       (dbg_sel),
        .dbg_data      (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    // Every address bit feeds the pattern
    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h0101_0101) ^ 32'h5ac3_96e1;
    endfunction

    function automatic int byte_count(input data_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic data_size_e pick_size(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   return SIZE_BYTE;
            32'd1:   return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // Word requests needed, two once the bytes pass the word end
    function automatic int words_touched(input logic [31:0] addr, input data_size_e size);
        return ((int'(addr[1:0]) + byte_count(size)) > 4) ? 2 : 1;
    endfunction

    // Byte-wise gather from the expected memory, then extension
    function automatic logic [31:0] load_value(input logic [31:0] addr,
                                               input data_size_e size, input logic uns);
        logic [31:0] val;
        logic [31:0] a;
        val = '0;
        for (int i = 0; i < byte_count(size); i++) begin
            a = addr + 32'(i);
            val[8*i +: 8] = exp_mem[a[9:2]][8*a[1:0] +: 8];
        end
        case (size)
            SIZE_BYTE: if (!uns) val[31:8] = {24{val[7]}};
            SIZE_HALF: if (!uns) val[31:16] = {16{val[15]}};
            default:   val = val;
        endcase
        return val;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    // Debug port is combinational, sampled 1 ns after the drive
    task automatic check_reg(input logic [4:0] r);
        dbg_sel = r;
        #1;
        check_eq(dbg_data, exp_regs[r], $sformatf("register x%0d", r));
        @(negedge clk);
    endtask

    task automatic check_mem(input logic [7:0] idx);
        check_eq(mem[idx], exp_mem[idx], $sformatf("memory word %0d", idx));
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic apply_reset();
        rstz = 1'b0;
        pipe_in_vld = 1'b0;
        repeat (16) @(negedge clk);
        rstz = 1'b1;
        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        check_eq(32'(branch), 32'd0, "branch after reset");
        check_eq(32'(dut.regwr_en), 32'd0, "regwr_en after reset");
        check_eq(32'(data_req.rd_req), 32'd0, "rd_req after reset");
        check_eq(32'(data_req.wr_req), 32'd0, "wr_req after reset");
        check_eq(32'(pipe_in_rdy), 32'd1, "pipe_in_rdy after reset");
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_bundle(input pipe_ex_wb_t b);
        execute = b;
        pipe_in_vld = 1'b1;
        while (!pipe_in_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        pipe_in_vld = 1'b0;
    endtask

    // Until the stage is free and the last write has landed
    task automatic wait_idle();
        while (!pipe_in_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic direct_write(input logic [4:0] rd, input logic wr, input logic [31:0] value);
        pipe_ex_wb_t b;
        b = '0;
        b.rd = rd;
        b.rd_write = wr;
        b.result1 = value;
        send_bundle(b);
        check_eq(32'(dut.regwr_en), 32'(wr), "regwr_en after direct bundle");
        @(negedge clk);
        check_eq(32'(dut.regwr_en), 32'd0, "regwr_en one cycle only");
        if (wr && rd != 5'd0) begin
            exp_regs[rd] = value;
        end
        check_reg(rd);
    endtask

    task automatic fire_branch(input logic uncond, input logic cond, input logic cond_bit);
        pipe_ex_wb_t b;
        logic [31:0] r;
        logic        expect_pulse;
        r = next_rand();
        b = '0;
        b.branch = uncond;
        b.branch_cond = cond;
        b.result1 = {r[31:1], cond_bit};
        b.result2 = next_rand();
        expect_pulse = uncond || (cond && cond_bit);
        send_bundle(b);
        check_eq(32'(branch), 32'(expect_pulse), "branch pulse");
        if (expect_pulse) begin
            check_eq(branch_target, b.result2, "branch target");
        end
        @(negedge clk);
        check_eq(32'(branch), 32'd0, "branch one cycle only");
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                               input data_size_e size);
        pipe_ex_wb_t b;
        logic [31:0] a;
        b = '0;
        b.st = 1'b1;
        b.result1 = addr;
        b.result2 = data;
        b.data_size = size;
        send_bundle(b);
        for (int i = 0; i < byte_count(size); i++) begin
            a = addr + 32'(i);
            exp_mem[a[9:2]][8*a[1:0] +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic issue_load(input logic [31:0] addr, input data_size_e size,
                              input logic uns, input logic [4:0] rd);
        pipe_ex_wb_t b;
        b = '0;
        b.ld = 1'b1;
        b.rd_write = 1'b1;
        b.rd = rd;
        b.result1 = addr;
        b.data_size = size;
        b.data_uns = uns;
        send_bundle(b);
        if (rd != 5'd0) begin
            exp_regs[rd] = load_value(addr, size, uns);
        end
    endtask

    task automatic run_store(input logic [31:0] addr, input logic [31:0] data,
                             input data_size_e size);
        int g0;
        g0 = gnt_count;
        issue_store(addr, data, size);
        wait_idle();
        check_eq(gnt_count - g0, words_touched(addr, size), "store request count");
        check_mem(addr[9:2]);
        check_mem(8'(addr[9:2] + 8'd1));
    endtask

    task automatic run_load(input logic [31:0] addr, input data_size_e size,
                            input logic uns, input logic [4:0] rd);
        int g0;
        g0 = gnt_count;
        issue_load(addr, size, uns, rd);
        wait_idle();
        check_eq(gnt_count - g0, words_touched(addr, size), "load request count");
        check_reg(rd);
    endtask

    // Store, then read back signed and unsigned
    task automatic mem_roundtrip(input logic [31:0] addr, input data_size_e size);
        run_store(addr, next_rand(), size);
        run_load(addr, size, 1'b0, 5'd10);
        run_load(addr, size, 1'b1, 5'd11);
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic direct_writes();
        pipe_ex_wb_t b;
        int          e0;
        e0 = errors;
        for (int r = 1; r < 6; r++) begin
            direct_write(5'(r), 1'b1, next_rand());
        end
        // x0 stays zero, rd_write low changes nothing
        direct_write(5'd0, 1'b1, 32'hdead_beef);
        direct_write(5'd6, 1'b0, next_rand());
        // One bundle per cycle
        for (int r = 12; r < 16; r++) begin
            b = '0;
            b.rd_write = 1'b1;
            b.rd = 5'(r);
            b.result1 = next_rand();
            check_eq(32'(pipe_in_rdy), 32'd1, "ready for back-to-back bundle");
            exp_regs[r] = b.result1;
            send_bundle(b);
        end
        wait_idle();
        for (int r = 12; r < 16; r++) begin
            check_reg(5'(r));
        end
        end_test("direct_writes", e0);
    endtask

    task automatic branch_pulses();
        int e0;
        e0 = errors;
        fire_branch(1'b1, 1'b0, 1'b0);
        fire_branch(1'b0, 1'b1, 1'b1);
        fire_branch(1'b0, 1'b1, 1'b0);
        fire_branch(1'b0, 1'b0, 1'b1);
        end_test("branch_pulses", e0);
    endtask

    task automatic aligned_accesses();
        int e0;
        e0 = errors;
        for (int o = 0; o < 4; o++) begin
            mem_roundtrip(32'h100 + 32'(o), SIZE_BYTE);
        end
        mem_roundtrip(32'h110, SIZE_HALF);
        mem_roundtrip(32'h112, SIZE_HALF);
        mem_roundtrip(32'h120, SIZE_WORD);
        end_test("aligned_accesses", e0);
    endtask

    task automatic crossing_accesses();
        int e0;
        e0 = errors;
        mem_roundtrip(32'h143, SIZE_HALF);
        mem_roundtrip(32'h151, SIZE_WORD);
        mem_roundtrip(32'h162, SIZE_WORD);
        mem_roundtrip(32'h173, SIZE_WORD);
        end_test("crossing_accesses", e0);
    endtask

    // Bundles issued without waiting, results compared at the end
    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        data_size_e  size;
        int          e0;
        e0 = errors;
        for (int n = 0; n < 24; n++) begin
            r = next_rand();
            addr = 32'h200 + {24'b0, r[7:0]};
            size = pick_size(next_rand());
            if (r[12]) begin
                issue_load(addr, size, r[13], (r[20:16] == 5'd0) ? 5'd1 : r[20:16]);
            end else begin
                issue_store(addr, next_rand(), size);
            end
        end
        wait_idle();
        for (int i = 1; i < 32; i++) begin
            check_reg(5'(i));
        end
        for (int i = 0; i < 256; i++) begin
            check_mem(8'(i));
        end
        check_eq(rdy_viol, 32'd0, "cycles with ready high during an access");
        check_eq(misaligned, 32'd0, "requests with an unaligned address");
        end_test("random_mix", e0);
    endtask

    task automatic illegal_halt();
        pipe_ex_wb_t b;
        int          e0;
        e0 = errors;
        b = '0;
        b.illegal = 1'b1;
        b.rd_write = 1'b1;
        b.rd = 5'd7;
        b.branch = 1'b1;
        b.result1 = next_rand();
        send_bundle(b);
        // A valid bundle waits in vain
        b = '0;
        b.rd_write = 1'b1;
        b.rd = 5'd8;
        b.result1 = next_rand();
        execute = b;
        pipe_in_vld = 1'b1;
        repeat (20) begin
            check_eq(32'(pipe_in_rdy), 32'd0, "ready after illegal bundle");
            check_eq(32'(branch), 32'd0, "branch after illegal bundle");
            check_eq(32'(dut.regwr_en), 32'd0, "regwr_en after illegal bundle");
            @(negedge clk);
        end
        pipe_in_vld = 1'b0;
        check_reg(5'd7);
        check_reg(5'd8);
        apply_reset();
        direct_write(5'd9, 1'b1, next_rand());
        end_test("illegal_halt", e0);
    endtask

    // ============================================================
    // Memory model
    // ============================================================

    initial begin
        data_gnt = 1'b0;
        data_rd_data = '0;
        wait_left = -1;
        gnt_count = 0;
        rdy_viol = 0;
        misaligned = 0;
        gnt_seed = 32'd41;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            // Grant lasts a single cycle
            data_gnt = 1'b0;
            if (!rstz) begin
                wait_left = -1;
            end else if (data_req.rd_req || data_req.wr_req) begin
                if (pipe_in_rdy) begin
                    rdy_viol++;
                end
                // New request, draw a delay of 0 to 3 cycles
                if (wait_left < 0) begin
                    gnt_seed = lcg_next(gnt_seed);
                    wait_left = int'(gnt_seed[17:16]);
                end
                if (wait_left == 0) begin
                    gnt_idx = data_req.addr[9:2];
                    if (data_req.addr[1:0] != 2'b00) begin
                        misaligned++;
                    end
                    if (data_req.wr_req) begin
                        for (int l = 0; l < 4; l++) begin
                            if (data_req.wr_mask[l]) begin
                                mem[gnt_idx][8*l +: 8] = data_req.wr_data[8*l +: 8];
                            end
                        end
                    end
                    data_rd_data = mem[gnt_idx];
                    data_gnt = 1'b1;
                    gnt_count++;
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        rstz = 1'b0;
        execute = '0;
        pipe_in_vld = 1'b0;
        dbg_sel = 5'd0;
        stim_seed = 32'd41;
        errors = 0;
        checks = 0;
        tests_run = 0;
        cycles = 0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = fill_word(i);
        end
        apply_reset();
        direct_writes();
        branch_pulses();
        aligned_accesses();
        crossing_accesses();
        random_mix();
        illegal_halt();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/wb_pipe_pkg.sv
hdl/data_bus_pkg.sv
hdl/load_store_unit.sv
hdl/wb_stage.sv
hdl/reg_file.sv
hdl/wb_top.sv
tests/tb_wb_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the write-back stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_wb_top -f flist.f -o tb_wb_top
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_wb_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
